//--- Makefile
# Verilator build and run of the pipelined CPU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuTb -f vlog.f
	@out="$$(./obj_dir/VcpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

  typedef logic [7:0]  word_t;
  typedef logic [15:0] instr_t;
  typedef logic [2:0]  regIdx_t;

  typedef enum logic [3:0] {
    OP_RTYPE = 4'd0,
    OP_LOAD  = 4'd2,
    OP_STORE = 4'd3,
    OP_JUMP  = 4'd4,
    OP_ADDI  = 4'd8,
    OP_BEQ   = 4'd9
  } opcode_e;

  typedef enum logic [2:0] {
    F_ADD = 3'd0,
    F_SUB = 3'd1,
    F_MUL = 3'd2,  // Decodes to nop
    F_DIV = 3'd3,
    F_AND = 3'd4,
    F_OR  = 3'd5,
    F_XOR = 3'd6,
    F_NOT = 3'd7
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOT,
    ALU_PASS
  } aluOp_e;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwdSel_e;

  function automatic opcode_e opcodeOf(instr_t instr);
    return opcode_e'(instr[15:12]);
  endfunction

  function automatic regIdx_t rdOf(instr_t instr);
    return instr[8:6];
  endfunction

  function automatic regIdx_t rs1Of(instr_t instr);
    return instr[5:3];
  endfunction

  function automatic regIdx_t rs2Of(instr_t instr);
    return instr[2:0];
  endfunction

  // Sign-extended 3-bit immediate
  function automatic word_t immOf(instr_t instr);
    return {{5{instr[2]}}, instr[2:0]};
  endfunction

endpackage

`default_nettype wire

//--- logic/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
  parameter int imemDepth = 64,
  parameter int dmemDepth = 256
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             run,
  input  logic             imemWrite,
  input  cpuPkg::word_t    imemAddr,
  input  cpuPkg::instr_t   imemData,
  output logic             wbValid,
  output cpuPkg::regIdx_t  wbReg,
  output cpuPkg::word_t    wbData
);

  cpuPkg::instr_t  instrD;
  cpuPkg::word_t   pcD;
  cpuPkg::regIdx_t rs1D;
  cpuPkg::regIdx_t rs2D;
  cpuPkg::regIdx_t loadRdE;
  cpuPkg::regIdx_t memRd;
  cpuPkg::word_t   redirectPc;
  cpuPkg::word_t   memResult;
  cpuPkg::fwdSel_e fwdA;
  cpuPkg::fwdSel_e fwdB;
  logic            stall;
  logic            flushDecode;
  logic            flushExecute;
  logic            redirect;
  logic            loadE;
  logic            memRegWrite;

  idExBus  idEx ();
  exMemBus exMem ();

  fetchStage #(.imemDepth(imemDepth)) u_fetchStage (
    .clk, .reset, .run, .stall, .flushDecode, .redirect, .redirectPc,
    .imemWrite, .imemAddr, .imemData, .instrD, .pcD
  );

  decodeStage u_decodeStage (
    .clk, .reset, .instrD, .pcD, .stall, .flushExecute,
    .wbValid, .wbReg, .wbData, .rs1D, .rs2D, .idEx(idEx.producer)
  );

  executeStage u_executeStage (
    .clk, .reset, .idEx(idEx.consumer), .fwdA, .fwdB, .memResult, .wbData,
    .redirect, .redirectPc, .loadRdE, .loadE, .exMem(exMem.producer)
  );

  memoryStage #(.dmemDepth(dmemDepth)) u_memoryStage (
    .clk, .reset, .exMem(exMem.consumer), .memResult, .memRd, .memRegWrite,
    .wbValid, .wbReg, .wbData
  );

  hazardUnit u_hazardUnit (
    .rs1D, .rs2D, .loadRdE, .memRd, .wbReg, .loadE, .memRegWrite, .wbValid,
    .redirect, .rs1E(idEx.rs1), .rs2E(idEx.rs2),
    .stall, .flushDecode, .flushExecute, .fwdA, .fwdB
  );

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic             clk,
  input  logic             reset,
  input  cpuPkg::instr_t   instrD,
  input  cpuPkg::word_t    pcD,
  input  logic             stall,
  input  logic             flushExecute,
  input  logic             wbValid,
  input  cpuPkg::regIdx_t  wbReg,
  input  cpuPkg::word_t    wbData,
  output cpuPkg::regIdx_t  rs1D,
  output cpuPkg::regIdx_t  rs2D,
  idExBus.producer         idEx
);

  cpuPkg::word_t   regs [8];
  cpuPkg::word_t   readA;
  cpuPkg::word_t   readB;
  cpuPkg::word_t   imm;
  cpuPkg::regIdx_t rd;
  cpuPkg::aluOp_e  aluOp;
  logic            writes;
  logic            useImm;
  logic            memRead;
  logic            memWrite;
  logic            isBranch;
  logic            isJump;
  logic            bubble;

  assign rd   = cpuPkg::rdOf(instrD);
  assign rs1D = cpuPkg::rs1Of(instrD);
  assign rs2D = cpuPkg::rs2Of(instrD);

  always_comb begin
    aluOp    = cpuPkg::ALU_PASS;
    imm      = cpuPkg::immOf(instrD);
    writes   = 1'b0;
    useImm   = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    isBranch = 1'b0;
    isJump   = 1'b0;
    case (cpuPkg::opcodeOf(instrD))
      cpuPkg::OP_RTYPE: begin
        writes = 1'b1;
        case (cpuPkg::funct_e'(instrD[11:9]))
          cpuPkg::F_ADD: aluOp = cpuPkg::ALU_ADD;
          cpuPkg::F_SUB: aluOp = cpuPkg::ALU_SUB;
          cpuPkg::F_AND: aluOp = cpuPkg::ALU_AND;
          cpuPkg::F_OR:  aluOp = cpuPkg::ALU_OR;
          cpuPkg::F_XOR: aluOp = cpuPkg::ALU_XOR;
          cpuPkg::F_NOT: aluOp = cpuPkg::ALU_NOT;
          default:       writes = 1'b0;  // mul, div
        endcase
      end
      cpuPkg::OP_ADDI: begin
        writes = 1'b1;
        useImm = 1'b1;
        aluOp  = cpuPkg::ALU_ADD;
      end
      cpuPkg::OP_LOAD: begin
        writes  = 1'b1;
        useImm  = 1'b1;
        memRead = 1'b1;
        aluOp   = cpuPkg::ALU_ADD;
      end
      cpuPkg::OP_STORE: memWrite = 1'b1;  // Address is rs1 as is
      cpuPkg::OP_BEQ: begin
        isBranch = 1'b1;
        imm      = {{5{rd[2]}}, rd};
      end
      cpuPkg::OP_JUMP: begin
        isJump = 1'b1;
        imm    = instrD[7:0];
      end
      default: ;
    endcase
  end

  // R0 is never written because wbValid excludes it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= cpuPkg::word_t'(i);
      end
    end else if (wbValid) begin
      regs[wbReg] <= wbData;
    end
  end

  function automatic cpuPkg::word_t readReg(cpuPkg::regIdx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wbValid && wbReg == idx) begin
      return wbData;  // Write lands this cycle
    end
    return regs[idx];
  endfunction

  always_comb begin
    readA = readReg(rs1D);
    readB = readReg(rs2D);
  end

  assign bubble = flushExecute || stall;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      idEx.regWrite <= 1'b0;
      idEx.memRead  <= 1'b0;
      idEx.memWrite <= 1'b0;
      idEx.isBranch <= 1'b0;
      idEx.isJump   <= 1'b0;
    end else begin
      idEx.regWrite <= !bubble && writes && rd != '0;
      idEx.memRead  <= !bubble && memRead;
      idEx.memWrite <= !bubble && memWrite;
      idEx.isBranch <= !bubble && isBranch;
      idEx.isJump   <= !bubble && isJump;
    end
  end

  always_ff @(posedge clk) begin
    idEx.operandA <= readA;
    idEx.operandB <= readB;
    idEx.imm      <= imm;
    idEx.pc       <= pcD;
    idEx.rd       <= rd;
    idEx.rs1      <= rs1D;
    idEx.rs2      <= rs2D;
    idEx.aluOp    <= aluOp;
    idEx.useImm   <= useImm;
  end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic             clk,
  input  logic             reset,
  idExBus.consumer         idEx,
  input  cpuPkg::fwdSel_e  fwdA,
  input  cpuPkg::fwdSel_e  fwdB,
  input  cpuPkg::word_t    memResult,
  input  cpuPkg::word_t    wbData,
  output logic             redirect,
  output cpuPkg::word_t    redirectPc,
  output cpuPkg::regIdx_t  loadRdE,
  output logic             loadE,
  exMemBus.producer        exMem
);

  cpuPkg::word_t opA;
  cpuPkg::word_t opB;
  cpuPkg::word_t aluB;
  cpuPkg::word_t aluResult;

  always_comb begin
    case (fwdA)
      cpuPkg::FWD_MEM: opA = memResult;
      cpuPkg::FWD_WB:  opA = wbData;
      default:         opA = idEx.operandA;
    endcase
    case (fwdB)
      cpuPkg::FWD_MEM: opB = memResult;
      cpuPkg::FWD_WB:  opB = wbData;
      default:         opB = idEx.operandB;
    endcase
  end

  assign aluB = idEx.useImm ? idEx.imm : opB;

  always_comb begin
    case (idEx.aluOp)
      cpuPkg::ALU_ADD: aluResult = opA + aluB;
      cpuPkg::ALU_SUB: aluResult = opA - aluB;
      cpuPkg::ALU_AND: aluResult = opA & aluB;
      cpuPkg::ALU_OR:  aluResult = opA | aluB;
      cpuPkg::ALU_XOR: aluResult = opA ^ aluB;
      cpuPkg::ALU_NOT: aluResult = ~opA;
      default:         aluResult = opA;  // Store address
    endcase
  end

  // Branch compares the forwarded values
  assign redirect   = idEx.isJump || (idEx.isBranch && opA == opB);
  assign redirectPc = idEx.isJump ? idEx.imm : idEx.pc + idEx.imm;

  assign loadE   = idEx.memRead;
  assign loadRdE = idEx.rd;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
    end else begin
      exMem.regWrite <= idEx.regWrite;
      exMem.memRead  <= idEx.memRead;
      exMem.memWrite <= idEx.memWrite;
    end
  end

  always_ff @(posedge clk) begin
    exMem.aluResult <= aluResult;
    exMem.storeData <= opB;
    exMem.rd        <= idEx.rd;
  end

endmodule

`default_nettype wire

//--- logic/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
  parameter int imemDepth = 64
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,
  input  logic            stall,
  input  logic            flushDecode,
  input  logic            redirect,
  input  cpuPkg::word_t   redirectPc,
  input  logic            imemWrite,
  input  cpuPkg::word_t   imemAddr,
  input  cpuPkg::instr_t  imemData,
  output cpuPkg::instr_t  instrD,
  output cpuPkg::word_t   pcD
);

  localparam int addrBits = $clog2(imemDepth);
  localparam cpuPkg::instr_t nopInstr = '0;  // add R0, R0, R0

  cpuPkg::instr_t imem [imemDepth];
  cpuPkg::word_t  pc;
  cpuPkg::instr_t instrF;

  always_ff @(posedge clk) begin
    if (imemWrite) begin
      imem[imemAddr[addrBits-1:0]] <= imemData;
    end
  end

  assign instrF = imem[pc[addrBits-1:0]];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (run && !stall) begin
      pc <= pc + 8'd1;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instrD <= nopInstr;
      pcD    <= '0;
    end else if (flushDecode || !run) begin
      instrD <= nopInstr;
      pcD    <= '0;
    end else if (!stall) begin
      instrD <= instrF;
      pcD    <= pc;
    end
  end

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  cpuPkg::regIdx_t  rs1D,
  input  cpuPkg::regIdx_t  rs2D,
  input  cpuPkg::regIdx_t  loadRdE,
  input  cpuPkg::regIdx_t  memRd,
  input  cpuPkg::regIdx_t  wbReg,
  input  logic             loadE,
  input  logic             memRegWrite,
  input  logic             wbValid,
  input  logic             redirect,
  input  cpuPkg::regIdx_t  rs1E,
  input  cpuPkg::regIdx_t  rs2E,
  output logic             stall,
  output logic             flushDecode,
  output logic             flushExecute,
  output cpuPkg::fwdSel_e  fwdA,
  output cpuPkg::fwdSel_e  fwdB
);

  logic loadUse;

  // Load result not ready for the instruction behind it
  assign loadUse = loadE && loadRdE != '0 && (loadRdE == rs1D || loadRdE == rs2D);

  assign stall        = loadUse;
  assign flushDecode  = redirect;
  assign flushExecute = loadUse || redirect;

  function automatic cpuPkg::fwdSel_e fwdFor(cpuPkg::regIdx_t src);
    if (memRegWrite && memRd != '0 && memRd == src) begin
      return cpuPkg::FWD_MEM;  // Youngest value wins
    end else if (wbValid && wbReg == src) begin
      return cpuPkg::FWD_WB;
    end
    return cpuPkg::FWD_REG;
  endfunction

  always_comb begin
    fwdA = fwdFor(rs1E);
    fwdB = fwdFor(rs2E);
  end

endmodule

`default_nettype wire

//--- logic/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage #(
  parameter int dmemDepth = 256
) (
  input  logic             clk,
  input  logic             reset,
  exMemBus.consumer        exMem,
  output cpuPkg::word_t    memResult,
  output cpuPkg::regIdx_t  memRd,
  output logic             memRegWrite,
  output logic             wbValid,
  output cpuPkg::regIdx_t  wbReg,
  output cpuPkg::word_t    wbData
);

  localparam int addrBits = $clog2(dmemDepth);

  cpuPkg::word_t dmem [dmemDepth];
  cpuPkg::word_t readData;
  logic          regWriteW;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < dmemDepth; i++) begin
        dmem[i] <= '0;
      end
    end else if (exMem.memWrite) begin
      dmem[exMem.aluResult[addrBits-1:0]] <= exMem.storeData;
    end
  end

  assign readData    = dmem[exMem.aluResult[addrBits-1:0]];
  assign memResult   = exMem.memRead ? readData : exMem.aluResult;
  assign memRd       = exMem.rd;
  assign memRegWrite = exMem.regWrite;

  // Memory/writeback register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteW <= 1'b0;
    end else begin
      regWriteW <= exMem.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbReg  <= exMem.rd;
    wbData <= memResult;
  end

  assign wbValid = regWriteW && wbReg != '0;

endmodule

`default_nettype wire

//--- logic/pipeBus.sv
`timescale 1ns/1ps
`default_nettype none

// Decode to execute
interface idExBus;
  cpuPkg::word_t   operandA;
  cpuPkg::word_t   operandB;
  cpuPkg::word_t   imm;       // Branch offset or jump target for control flow
  cpuPkg::word_t   pc;
  cpuPkg::regIdx_t rd;
  cpuPkg::regIdx_t rs1;
  cpuPkg::regIdx_t rs2;
  cpuPkg::aluOp_e  aluOp;
  logic            useImm;
  logic            regWrite;
  logic            memRead;
  logic            memWrite;
  logic            isBranch;
  logic            isJump;

  modport producer (
    output operandA, operandB, imm, pc, rd, rs1, rs2, aluOp,
    output useImm, regWrite, memRead, memWrite, isBranch, isJump
  );

  modport consumer (
    input operandA, operandB, imm, pc, rd, rs1, rs2, aluOp,
    input useImm, regWrite, memRead, memWrite, isBranch, isJump
  );
endinterface

// Execute to memory
interface exMemBus;
  cpuPkg::word_t   aluResult;
  cpuPkg::word_t   storeData;
  cpuPkg::regIdx_t rd;
  logic            regWrite;
  logic            memRead;
  logic            memWrite;

  modport producer (output aluResult, storeData, rd, regWrite, memRead, memWrite);
  modport consumer (input aluResult, storeData, rd, regWrite, memRead, memWrite);
endinterface

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam int maxWords    = 64;
  localparam int maxChecks   = 64;
  localparam int tailCycles  = 20;
  localparam int clkPeriod   = 20;
  localparam int markComment = 35;   // '#'
  localparam int markInstr   = 105;  // 'i'
  localparam int markWb      = 119;  // 'w'
  localparam int newLine     = 10;

  logic        clk;
  logic        reset;
  logic        run;
  logic        imemWrite;
  logic [7:0]  imemAddr;
  logic [15:0] imemData;
  logic        wbValid;
  logic [2:0]  wbReg;
  logic [7:0]  wbData;

  logic [15:0] progWords [maxWords];
  logic [2:0]  expReg [maxChecks];
  logic [7:0]  expData [maxChecks];
  int          progLen;
  int          expCount;
  int          seen;
  int          errors;
  logic        dataReady;

  cpuTop u_cpuTop (
    .clk(clk),
    .reset(reset),
    .run(run),
    .imemWrite(imemWrite),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .wbValid(wbValid),
    .wbReg(wbReg),
    .wbData(wbData)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic readTestData();
    int fd;
    int ch;
    int got;
    int a;
    int b;
    fd = $fopen("tests/cpu_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/cpu_testdata.txt");
      return;
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == markComment) begin
        while (ch != -1 && ch != newLine) begin
          ch = $fgetc(fd);
        end
      end else if (ch == markInstr && progLen < maxWords) begin
        got = $fscanf(fd, "%h", a);
        if (got == 1) begin
          progWords[progLen] = 16'(a);
          progLen++;
        end
      end else if (ch == markWb && expCount < maxChecks) begin
        got = $fscanf(fd, "%h %h", a, b);
        if (got == 2) begin
          expReg[expCount]  = 3'(a);
          expData[expCount] = 8'(b);
          expCount++;
        end
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // Random idle gaps between program writes
  task automatic loadProgram();
    int gap;
    for (int a = 0; a < progLen; a++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        @(posedge clk);
        imemWrite <= 1'b0;
      end
      @(posedge clk);
      imemWrite <= 1'b1;
      imemAddr  <= 8'(a);
      imemData  <= progWords[a];
    end
    @(posedge clk);
    imemWrite <= 1'b0;
  endtask

  task automatic checkWriteback();
    assert (wbReg == expReg[seen]) else begin
      errors++;
      $display("ERROR wbReg: writeback %0d is %h, expected %h", seen, wbReg, expReg[seen]);
    end
    assert (wbData == expData[seen]) else begin
      errors++;
      $display("ERROR wbData: writeback %0d to R%0d is %h, expected %h",
               seen, wbReg, wbData, expData[seen]);
    end
  endtask

  // Outputs settle after the rising edge
  always @(negedge clk) begin
    if (!reset && wbValid) begin
      assert (run) else begin
        errors++;
        $display("A writeback appeared while run was still low");
      end
      assert (seen < expCount) else begin
        errors++;
        $display("Unexpected extra writeback to R%0d with value %h", wbReg, wbData);
      end
      if (seen < expCount) begin
        checkWriteback();
        seen++;
      end
    end
  end

  task automatic runProgram();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    loadProgram();
    @(posedge clk);
    run <= 1'b1;
    wait (seen == expCount);
    repeat (tailCycles) @(posedge clk);  // Catch stray writebacks
    $display("Writebacks checked %0d of %0d, errors %0d", seen, expCount, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    run       = 1'b0;
    imemWrite = 1'b0;
    imemAddr  = '0;
    imemData  = '0;
    progLen   = 0;
    expCount  = 0;
    seen      = 0;
    errors    = 0;
    dataReady = 1'b0;
    void'($urandom(32'hab91a134));
    readTestData();
    if (progLen == 0 || expCount == 0) begin
      $display("Test data file is missing or holds no program or writebacks");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      dataReady = 1'b1;
      runProgram();
    end
  end

  // Watchdog scaled to the program size
  initial begin
    wait (dataReady);
    #((progLen + expCount) * 10 * clkPeriod);
    $display("Timeout with only %0d of %0d writebacks seen, errors %0d",
             seen, expCount, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/cpu_testdata.txt
# Lines i <hex word> hold the program from address 0 upward
# Lines w <reg> <hex value> hold the expected writebacks in order
i 8043  # addi R1, R0, 3
i 8084  # addi R2, R0, -4
i 80CA  # addi R3, R1, 2
i 011A  # add  R4, R3, R2
i 0361  # sub  R5, R4, R1
i 09AB  # and  R6, R5, R3
i 0BF5  # or   R7, R6, R5
i 0C7A  # xor  R1, R7, R2
i 0E88  # not  R2, R1
i 301A  # store [R3] <= R2
i 210B  # load R4, R1, 3
i 0164  # add  R5, R4, R4 after load
i 002D  # add  R0, R5, R5 ignored
i 05AD  # mul  decodes to nop
i 0185  # add  R6, R0, R5
i 90EE  # beq  R5, R6, +3 taken
i 8041  # skipped
i 8081  # skipped
i 90CA  # beq  R1, R2, +3 not taken
i 81F9  # addi R7, R7, 1
i 4017  # jump 23
i 8042  # skipped
i 8082  # skipped
i 80DF  # addi R3, R3, -1
i 4018  # jump to itself
i 8101  # never runs
i 8141  # never runs
w 1 03
w 2 FC
w 3 05
w 4 01
w 5 FE
w 6 04
w 7 FE
w 1 02
w 2 FD
w 4 FD
w 5 FA
w 6 FA
w 7 FF
w 3 04

//--- vlog.f
logic/cpuPkg.sv
logic/pipeBus.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/cpuTop.sv
tests/cpuTb.sv
